// File: include/knight_defines.svh
`ifndef KNIGHT_DEFINES_SVH
`define KNIGHT_DEFINES_SVH

// Length of a gyro calibration in clock cycles
`define KN_CAL_CYCLES 64

// Cycles it takes the knight to travel one square
`define KN_SQUARE_CYCLES 16

// Opcodes, carried in the top nibble of the command word
`define KN_OP_CAL 4'h2
`define KN_OP_MOVE 4'h4
`define KN_OP_TOUR 4'h6

// Response bytes; a NAK carries its reason in the low nibble
`define KN_RESP_ACK 8'hA5
`define KN_RESP_NAK_BASE 8'hE0

// Square the knight starts on after reset
`define KN_START_XX 3'd2
`define KN_START_YY 3'd2

`endif

// File: src/knightCmdPkg.sv
package knightCmdPkg;

  //////////////////////////////
  // Command classification
  //////////////////////////////

  // Kind of command after the opcode has been looked at
  typedef enum logic [1:0] {
    CAL  = 2'd0,
    MOVE = 2'd1,
    TOUR = 2'd2,
    BAD  = 2'd3
  } cmdKind_e;

  //////////////////////////////
  // Payload layouts
  //////////////////////////////

  // Move payload with the upper heading byte above the number of squares
  typedef struct packed {
    logic [7:0] heading;
    logic [3:0] squares;
  } movePayload_s;

  // Tour start payload holding the target square between padding bits
  typedef struct packed {
    logic       rsvdHi;
    logic [2:0] xx;
    logic       rsvdMid;
    logic [2:0] yy;
    logic [3:0] rsvdLo;
  } tourPayload_s;

  // The same 12 payload bits seen as either layout
  typedef union packed {
    movePayload_s move;
    tourPayload_s tour;
  } cmdPayload_u;

  // What decode hands to execute
  typedef struct packed {
    cmdKind_e    kind;
    cmdPayload_u payload;
  } decodedCmd_s;

  // Completion status whose value is also the NAK reason code
  typedef enum logic [1:0] {
    OK        = 2'd0,
    NOT_CAL   = 2'd1,
    OFF_BOARD = 2'd2,
    BAD_CMD   = 2'd3
  } execStatus_e;

endpackage

// File: src/knightBoardPkg.sv
package knightBoardPkg;

  //////////////////////////////
  // Board geometry
  //////////////////////////////

  // Position on the 8 by 8 board
  // xx counts columns west to east, yy counts rows south to north
  typedef struct packed {
    logic [2:0] xx;
    logic [2:0] yy;
  } square_s;

  // Legal compass headings as the upper byte of a gyro heading
  // Every other byte value is an illegal heading
  typedef enum logic [7:0] {
    NORTH = 8'h00,
    WEST  = 8'h3F,
    SOUTH = 8'h7F,
    EAST  = 8'hBF
  } heading_e;

endpackage

// File: src/knightCmdDecode.sv
`timescale 1ns/1ns
`include "knight_defines.svh"

module knightCmdDecode import knightCmdPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [15:0] cmd,
  input  logic        cmdRdy,
  output decodedCmd_s dec,
  output logic        decValid
);

  // Copy of the last command word that arrived with a strobe
  logic [15:0] cmdReg;

  //////////////////////////////
  // Capture
  //////////////////////////////

  // The word itself only changes on a strobe
  always_ff @(posedge clk) begin
    if (cmdRdy) begin
      cmdReg <= cmd;
    end
  end

  // The valid pulse trails the strobe by exactly one cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      decValid <= 1'b0;
    end else begin
      decValid <= cmdRdy;
    end
  end

  //////////////////////////////
  // Classify
  //////////////////////////////

  // Only the opcode nibble is judged here
  // The payload goes through untouched, execute reads it as it needs
  always_comb begin
    case (cmdReg[15:12])
      `KN_OP_CAL:  dec.kind = CAL;
      `KN_OP_MOVE: dec.kind = MOVE;
      `KN_OP_TOUR: dec.kind = TOUR;
      // Anything else comes back as a bad command
      default:     dec.kind = BAD;
    endcase
    dec.payload = cmdReg[11:0];
  end

endmodule

// File: src/knightMoveExec.sv
`timescale 1ns/1ns
`include "knight_defines.svh"

module knightMoveExec import knightCmdPkg::*, knightBoardPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  decodedCmd_s dec,
  input  logic        decValid,
  output logic        busy,
  output logic        calDone,
  output square_s     pos,
  output execStatus_e doneStatus,
  output logic        doneValid
);

  // One counter serves both calibration and square timing
  localparam int cntW = $clog2(`KN_CAL_CYCLES + `KN_SQUARE_CYCLES);
  localparam logic [cntW-1:0] calLast = cntW'(`KN_CAL_CYCLES - 1);
  localparam logic [cntW-1:0] sqLast = cntW'(`KN_SQUARE_CYCLES - 1);
  localparam square_s startPos = '{xx: `KN_START_XX, yy: `KN_START_YY};

  typedef enum logic [1:0] {
    StIdle,
    StCal,
    StMove
  } execState_e;

  execState_e state;
  logic [cntW-1:0] cycCnt;
  logic [3:0] sqLeft;
  heading_e moveHeading;

  // Move request fields, read through the union
  heading_e reqHeading;
  logic [3:0] reqSquares;
  logic headingOk;
  logic destOk;
  logic [4:0] xxReach;
  logic [4:0] yyReach;
  square_s stepPos;

  //////////////////////////////
  // Move checks
  //////////////////////////////

  assign reqHeading = heading_e'(dec.payload.move.heading);
  assign reqSquares = dec.payload.move.squares;

  // Furthest column or row reached going east or north
  assign xxReach = {2'b00, pos.xx} + {1'b0, reqSquares};
  assign yyReach = {2'b00, pos.yy} + {1'b0, reqSquares};

  // A move is only started if its heading is one of the four legal
  // bytes and the whole path stays on the board
  always_comb begin
    headingOk = 1'b1;
    destOk    = 1'b0;
    case (reqHeading)
      EAST:  destOk = (xxReach <= 5'd7);
      WEST:  destOk = (reqSquares <= {1'b0, pos.xx});
      NORTH: destOk = (yyReach <= 5'd7);
      SOUTH: destOk = (reqSquares <= {1'b0, pos.yy});
      default: headingOk = 1'b0;
    endcase
  end

  // Next square along the heading of the move in progress
  always_comb begin
    stepPos = pos;
    case (moveHeading)
      EAST:  stepPos.xx = pos.xx + 3'd1;
      WEST:  stepPos.xx = pos.xx - 3'd1;
      NORTH: stepPos.yy = pos.yy + 3'd1;
      SOUTH: stepPos.yy = pos.yy - 3'd1;
      default: stepPos = pos;
    endcase
  end

  //////////////////////////////
  // Command FSM
  //////////////////////////////

  // Commands that finish at once never raise busy
  // busy drops on the same edge that raises doneValid
  always_ff @(posedge clk) begin
    if (!rstN) begin
      state       <= StIdle;
      cycCnt      <= '0;
      sqLeft      <= '0;
      moveHeading <= NORTH;
      busy        <= 1'b0;
      calDone     <= 1'b0;
      pos         <= startPos;
      doneStatus  <= OK;
      doneValid   <= 1'b0;
    end else begin
      doneValid <= 1'b0;
      case (state)
        StIdle: begin
          cycCnt <= '0;
          // Strobes that arrive outside idle are dropped
          if (decValid) begin
            case (dec.kind)
              CAL: begin
                state <= StCal;
                busy  <= 1'b1;
              end
              TOUR: begin
                pos.xx     <= dec.payload.tour.xx;
                pos.yy     <= dec.payload.tour.yy;
                doneStatus <= OK;
                doneValid  <= 1'b1;
              end
              MOVE: begin
                if (!calDone) begin
                  doneStatus <= NOT_CAL;
                  doneValid  <= 1'b1;
                end else if (!headingOk || !destOk) begin
                  // Illegal headings share the off-board code
                  doneStatus <= OFF_BOARD;
                  doneValid  <= 1'b1;
                end else if (reqSquares == 4'd0) begin
                  doneStatus <= OK;
                  doneValid  <= 1'b1;
                end else begin
                  state       <= StMove;
                  busy        <= 1'b1;
                  sqLeft      <= reqSquares;
                  moveHeading <= reqHeading;
                end
              end
              default: begin
                doneStatus <= BAD_CMD;
                doneValid  <= 1'b1;
              end
            endcase
          end
        end
        StCal: begin
          if (cycCnt == calLast) begin
            state      <= StIdle;
            busy       <= 1'b0;
            calDone    <= 1'b1;
            doneStatus <= OK;
            doneValid  <= 1'b1;
          end else begin
            cycCnt <= cycCnt + 1'b1;
          end
        end
        StMove: begin
          if (cycCnt == sqLast) begin
            // One more square covered
            cycCnt <= '0;
            pos    <= stepPos;
            sqLeft <= sqLeft - 4'd1;
            if (sqLeft == 4'd1) begin
              state      <= StIdle;
              busy       <= 1'b0;
              doneStatus <= OK;
              doneValid  <= 1'b1;
            end
          end else begin
            cycCnt <= cycCnt + 1'b1;
          end
        end
        default: begin
          state <= StIdle;
          busy  <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: src/knightRespGen.sv
`timescale 1ns/1ns
`include "knight_defines.svh"

module knightRespGen import knightCmdPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  execStatus_e doneStatus,
  input  logic        doneValid,
  output logic [7:0]  resp,
  output logic        respRdy
);

  // Byte that goes out for the status now on the input
  logic [7:0] respByte;

  //////////////////////////////
  // Encode
  //////////////////////////////

  // Success is a plain ACK, every failure is a NAK with its code
  always_comb begin
    if (doneStatus == OK) begin
      respByte = `KN_RESP_ACK;
    end else begin
      respByte = `KN_RESP_NAK_BASE | {6'd0, doneStatus};
    end
  end

  //////////////////////////////
  // Register
  //////////////////////////////

  // The byte stays put between responses
  always_ff @(posedge clk) begin
    if (doneValid) begin
      resp <= respByte;
    end
  end

  // Ready is a single-cycle pulse, one cycle behind doneValid
  always_ff @(posedge clk) begin
    if (!rstN) begin
      respRdy <= 1'b0;
    end else begin
      respRdy <= doneValid;
    end
  end

endmodule

// File: src/knightCmdProc.sv
`timescale 1ns/1ns

module knightCmdProc import knightCmdPkg::*, knightBoardPkg::*; (
  input  logic        clk,
  input  logic        rstN,
  input  logic [15:0] cmd,
  input  logic        cmdRdy,
  output logic        busy,
  output logic        calDone,
  output square_s     pos,
  output logic [7:0]  resp,
  output logic        respRdy
);

  // Decode to execute
  decodedCmd_s dec;
  logic decValid;

  // Execute to response
  execStatus_e doneStatus;
  logic doneValid;

  //////////////////////////////
  // Pipeline
  //////////////////////////////

  knightCmdDecode u_knightCmdDecode (
    .clk      (clk),
    .rstN     (rstN),
    .cmd      (cmd),
    .cmdRdy   (cmdRdy),
    .dec      (dec),
    .decValid (decValid)
  );

  // Holds the board state and runs each command to completion
  knightMoveExec u_knightMoveExec (
    .clk        (clk),
    .rstN       (rstN),
    .dec        (dec),
    .decValid   (decValid),
    .busy       (busy),
    .calDone    (calDone),
    .pos        (pos),
    .doneStatus (doneStatus),
    .doneValid  (doneValid)
  );

  knightRespGen u_knightRespGen (
    .clk        (clk),
    .rstN       (rstN),
    .doneStatus (doneStatus),
    .doneValid  (doneValid),
    .resp       (resp),
    .respRdy    (respRdy)
  );

endmodule

// File: verification/knightCmdProc_assert.sv
`timescale 1ns/1ns
`include "knight_defines.svh"

module knightCmdProc_assert (
  input logic clk,
  input logic rstN,
  input logic decValid,
  input logic busy,
  input logic respRdy
);

  // Longest command is a calibration or a move across fifteen squares, plus slack
  localparam int maxLat = `KN_CAL_CYCLES + 16 * `KN_SQUARE_CYCLES;

  // Set by a decoded command, cleared by the response that answers it
  logic pending;
  int waitCnt;
  int failCount = 0;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pending <= 1'b0;
      waitCnt <= 0;
    end else if (decValid && (!pending || respRdy)) begin
      pending <= 1'b1;
      waitCnt <= 0;
    end else if (respRdy) begin
      pending <= 1'b0;
    end else if (pending) begin
      waitCnt <= waitCnt + 1;
    end
  end

  //////////////////////////////
  // Response properties
  //////////////////////////////

  // Ready never lasts more than one cycle
  respPulse: assert property (@(posedge clk) disable iff (!rstN) respRdy |=> !respRdy)
    else begin
      failCount++;
      $error("respRdy stayed high for more than one cycle");
    end

  // The command is finished by the time its response goes out
  respIdle: assert property (@(posedge clk) disable iff (!rstN) respRdy |-> !busy)
    else begin
      failCount++;
      $error("busy was high in a respRdy cycle");
    end

  respBound: assert property (@(posedge clk) disable iff (!rstN) !(pending && waitCnt > maxLat))
    else begin
      failCount++;
      $error("no respRdy within %0d cycles of decValid", maxLat);
    end

endmodule

// File: verification/knightCmdProc_tb.sv
`timescale 1ns/1ns
`include "knight_defines.svh"

module knightCmdProc_tb import knightBoardPkg::*; ();

  logic clk;
  logic rstN;
  logic [15:0] cmd;
  logic cmdRdy;
  logic busy;
  logic calDone;
  logic [7:0] resp;
  logic respRdy;
  square_s pos;

  int seed = 71;
  int errCount = 0;
  int checkCount = 0;
  int testCount = 0;
  int cycleNo = 0;
  bit runOver = 1'b0;

  // What the board should look like once every sent command is answered
  square_s modelPos;
  logic modelCal;

  // One entry per command still waiting for its response
  logic [7:0] expRespQ[$];
  square_s expPosQ[$];
  int expLatQ[$];
  int sendCycQ[$];

  knightCmdProc u_knightCmdProc (
    .clk     (clk),
    .rstN    (rstN),
    .cmd     (cmd),
    .cmdRdy  (cmdRdy),
    .busy    (busy),
    .calDone (calDone),
    .pos     (pos),
    .resp    (resp),
    .respRdy (respRdy)
  );

  bind knightCmdProc knightCmdProc_assert u_knightCmdProcAssert (
    .clk      (clk),
    .rstN     (rstN),
    .decValid (decValid),
    .busy     (busy),
    .respRdy  (respRdy)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  always @(posedge clk) cycleNo <= cycleNo + 1;

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Expected response, position and calibration after one command
  function automatic void predictCmd(input logic [15:0] word, input square_s curPos,
                                     input logic curCal, output logic [7:0] expResp,
                                     output square_s expPos, output logic expCal);
    int dx;
    int dy;
    int nx;
    int ny;
    int steps;
    expPos = curPos;
    expCal = curCal;
    expResp = `KN_RESP_ACK;
    steps = int'(word[3:0]);
    dx = 0;
    dy = 0;
    case (word[15:12])
      `KN_OP_CAL: expCal = 1'b1;
      `KN_OP_TOUR: begin
        expPos.xx = word[10:8];
        expPos.yy = word[6:4];
      end
      `KN_OP_MOVE: begin
        if (!curCal) begin
          expResp = `KN_RESP_NAK_BASE | 8'h1;
        end else begin
          case (word[11:4])
            NORTH: dy = steps;
            SOUTH: dy = -steps;
            EAST: dx = steps;
            WEST: dx = -steps;
            default: expResp = `KN_RESP_NAK_BASE | 8'h2;
          endcase
          nx = int'(curPos.xx) + dx;
          ny = int'(curPos.yy) + dy;
          // A path that ends off the board is refused before it starts
          if (expResp == `KN_RESP_ACK) begin
            if (nx < 0 || nx > 7 || ny < 0 || ny > 7) begin
              expResp = `KN_RESP_NAK_BASE | 8'h2;
            end else begin
              expPos.xx = nx[2:0];
              expPos.yy = ny[2:0];
            end
          end
        end
      end
      default: expResp = `KN_RESP_NAK_BASE | 8'h3;
    endcase
  endfunction

  function automatic logic [15:0] moveWord(input heading_e hdg, input logic [3:0] n);
    return {`KN_OP_MOVE, hdg, n};
  endfunction

  function automatic logic [15:0] tourWord(input logic [2:0] xx, input logic [2:0] yy);
    return {`KN_OP_TOUR, 1'b0, xx, 1'b0, yy, 4'h0};
  endfunction

  // Random square count that keeps the knight on the board
  function automatic logic [3:0] pickSquares(input int room);
    int r;
    r = $random(seed);
    if (room <= 0) begin
      return 4'd0;
    end
    return 4'(1 + ($unsigned(r) % room));
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  task automatic checkResp(input logic [7:0] got, input logic [7:0] exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("CHECK FAILED at %0t ns: resp got %02h expected %02h", $time, got, exp);
    end
  endtask

  task automatic checkPos(input square_s got, input square_s exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("CHECK FAILED at %0t ns: pos got (%0d,%0d) expected (%0d,%0d)",
               $time, got.xx, got.yy, exp.xx, exp.yy);
    end
  endtask

  task automatic checkLevel(input string name, input logic got, input logic exp);
    checkCount++;
    if (got !== exp) begin
      errCount++;
      $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  task automatic checkCycles(input int got, input int exp);
    checkCount++;
    if (got != exp) begin
      errCount++;
      $display("CHECK FAILED at %0t ns: respRdy latency got %0d expected %0d",
               $time, got, exp);
    end
  endtask

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // A latency of zero means the response time is not checked
  task automatic sendCmd(input logic [15:0] word, input int expLat);
    logic [7:0] eResp;
    square_s ePos;
    logic eCal;
    predictCmd(word, modelPos, modelCal, eResp, ePos, eCal);
    modelPos = ePos;
    modelCal = eCal;
    expRespQ.push_back(eResp);
    expPosQ.push_back(ePos);
    expLatQ.push_back(expLat);
    @(posedge clk);
    #1;
    cmd = word;
    cmdRdy = 1'b1;
    sendCycQ.push_back(cycleNo);
    @(posedge clk);
    #1;
    cmdRdy = 1'b0;
  endtask

  task automatic waitResponses();
    int waited;
    waited = 0;
    while (expRespQ.size() != 0 && waited < 2100) begin
      @(posedge clk);
      #3;
      waited++;
    end
    if (expRespQ.size() != 0) begin
      errCount++;
      $display("Gave up waiting for the outstanding responses at %0t ns", $time);
      runOver = 1'b1;
    end
  endtask

  task automatic waitBusy();
    int waited;
    waited = 0;
    while (busy !== 1'b1 && waited < 50) begin
      @(posedge clk);
      #1;
      waited++;
    end
    if (busy !== 1'b1) begin
      errCount++;
      $display("busy never rose after the move was sent");
    end
  endtask

  task automatic endTest(input string name, input int errsBefore);
    testCount++;
    $display("Test %0d %s: %s", testCount, name, (errCount == errsBefore) ? "passed" : "failed");
  endtask

  //////////////////////////////
  // Response checker
  //////////////////////////////

  initial begin : compareResponses
    int waited;
    int sendCyc;
    int eLat;
    logic [7:0] eResp;
    square_s ePos;
    waited = 0;
    forever begin
      @(posedge clk);
      #2;
      if (respRdy === 1'b1) begin
        waited = 0;
        if (expRespQ.size() == 0) begin
          errCount++;
          $display("Response %02h at %0t ns came with no command outstanding", resp, $time);
        end else begin
          eResp = expRespQ.pop_front();
          ePos = expPosQ.pop_front();
          eLat = expLatQ.pop_front();
          sendCyc = sendCycQ.pop_front();
          checkResp(resp, eResp);
          checkPos(pos, ePos);
          if (eLat > 0) begin
            checkCycles(cycleNo - sendCyc, eLat);
          end
        end
      end else if (expRespQ.size() != 0) begin
        waited++;
        if (waited >= 2000) begin
          errCount++;
          $display("No respRdy for 2000 cycles at %0t ns", $time);
          runOver = 1'b1;
          waited = 0;
        end
      end
    end
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin : runTests
    int errs;
    square_s tgt;
    cmd = 16'h0000;
    cmdRdy = 1'b0;
    rstN = 1'b0;
    modelPos = '{xx: `KN_START_XX, yy: `KN_START_YY};
    modelCal = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    rstN = 1'b1;

    // Reset state, then a move before the gyro is calibrated
    errs = errCount;
    checkLevel("busy", busy, 1'b0);
    checkLevel("respRdy", respRdy, 1'b0);
    checkLevel("calDone", calDone, 1'b0);
    checkPos(pos, modelPos);
    sendCmd(16'h4BF1, 3);
    waitResponses();
    endTest("move before calibration", errs);

    errs = errCount;
    sendCmd({`KN_OP_CAL, 12'h000}, 2 + `KN_CAL_CYCLES + 1);
    waitResponses();
    checkLevel("calDone", calDone, 1'b1);
    endTest("calibration", errs);

    // East by one, then random runs north, south and west
    errs = errCount;
    sendCmd(16'h4BF1, 0);
    waitResponses();
    sendCmd(moveWord(NORTH, pickSquares(7 - int'(modelPos.yy))), 0);
    waitResponses();
    sendCmd(moveWord(SOUTH, pickSquares(int'(modelPos.yy))), 0);
    waitResponses();
    sendCmd(moveWord(WEST, pickSquares(int'(modelPos.xx))), 0);
    waitResponses();
    endTest("moves", errs);

    errs = errCount;
    sendCmd(moveWord(EAST, 4'(8 - int'(modelPos.xx))), 3);
    waitResponses();
    sendCmd({`KN_OP_MOVE, 8'h12, 4'd1}, 3);
    waitResponses();
    endTest("refused moves", errs);

    errs = errCount;
    tgt.xx = 3'($random(seed));
    tgt.yy = 3'($random(seed));
    sendCmd(tourWord(tgt.xx, tgt.yy), 3);
    waitResponses();
    sendCmd(16'hF123, 3);
    waitResponses();
    endTest("tour start and unknown opcode", errs);

    // A strobe during a running move is dropped without a response
    errs = errCount;
    sendCmd(tourWord(3'd1, 3'd1), 3);
    waitResponses();
    sendCmd(moveWord(NORTH, 4'd4), 0);
    waitBusy();
    repeat (5) @(posedge clk);
    #1;
    cmd = tourWord(3'd6, 3'd6);
    cmdRdy = 1'b1;
    @(posedge clk);
    #1;
    cmdRdy = 1'b0;
    waitResponses();
    repeat (20) @(posedge clk);
    #3;
    checkPos(pos, modelPos);
    endTest("strobe while busy", errs);

    runOver = 1'b1;
  end

  initial begin : finishRun
    int cycles;
    cycles = 0;
    while (!runOver && cycles < 20000) begin
      @(posedge clk);
      cycles++;
    end
    if (!runOver) begin
      errCount++;
      $display("Simulation ran past its limit of 20000 cycles");
    end
    errCount += u_knightCmdProc.u_knightCmdProcAssert.failCount;
    $display("Tests %0d, checks %0d, errors %0d", testCount, checkCount, errCount);
    if (errCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// File: knightCmdProc.f
+incdir+include
src/knightCmdPkg.sv
src/knightBoardPkg.sv
src/knightCmdDecode.sv
src/knightMoveExec.sv
src/knightRespGen.sv
src/knightCmdProc.sv
verification/knightCmdProc_assert.sv
verification/knightCmdProc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the knightCmdProc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module knightCmdProc_tb \
  -f knightCmdProc.f \
  -o knightCmdProc_sim

out=$(./obj_dir/knightCmdProc_sim)
echo "$out"

if echo "$out" | grep -q "NO ERRORS"; then
  exit 0
fi
exit 1
